// ==== serial_cpu_pkg.sv ====
// serial cpu shared types
package serial_cpu_pkg;

    // ------------------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------------------
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  reg_idx_t;

    localparam int NUM_REGS = 8;

    // ------------------------------------------------------------------------
    // instruction set
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        NOP   = 5'b00000,
        HALT  = 5'b00001,
        LOAD  = 5'b00010,
        STORE = 5'b00011,
        SLL   = 5'b00100,
        SRL   = 5'b00110,
        ADD   = 5'b01000,
        ADDI  = 5'b01001,
        SUB   = 5'b01010,
        SUBI  = 5'b01011,
        CMP   = 5'b01100,
        AND   = 5'b01101,
        OR    = 5'b01110,
        XOR   = 5'b01111,
        LDIH  = 5'b10000,
        SUIH  = 5'b10011,
        SET   = 5'b10100,
        JUMP  = 5'b11000,
        JMPR  = 5'b11001,
        BZ    = 5'b11010,
        BNZ   = 5'b11011,
        BN    = 5'b11100,
        BNN   = 5'b11101,
        BC    = 5'b11110,
        BNC   = 5'b11111
    } opcode_e;

    // imm8 is {r2, r3}
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   r1;
        logic [3:0] r2;
        logic [3:0] r3;
    } instr_t;

    // [2:1] of a branch condition picks the flag and [0] is the level that branches
    localparam logic [2:0] BR_NONE = 3'b000;
    localparam logic [2:0] BR_NZ   = 3'b010;
    localparam logic [2:0] BR_Z    = 3'b011;
    localparam logic [2:0] BR_NN   = 3'b100;
    localparam logic [2:0] BR_N    = 3'b101;
    localparam logic [2:0] BR_NC   = 3'b110;
    localparam logic [2:0] BR_C    = 3'b111;

    // ------------------------------------------------------------------------
    // control and status
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        IF   = 3'd1,
        IF2  = 3'd2,
        ID   = 3'd3,
        EX   = 3'd4,
        MEM  = 3'd5,
        MEM2 = 3'd6,
        WB   = 3'd7
    } cpu_state_e;

    typedef struct packed {
        logic       writes_reg;
        logic       sets_flags;
        logic       is_load;
        logic       is_store;
        logic       is_branch_uncond;
        logic       is_halt;
        logic [2:0] branch_cond;
        reg_idx_t   dst;
    } dec_t;

    // one strobe per active state
    typedef struct packed {
        logic load_ir_hi;
        logic load_ir_lo;
        logic latch_operands;
        logic execute;
        logic mem_lo;
        logic mem_hi;
        logic writeback;
    } step_t;

    typedef struct packed {
        logic zf;
        logic nf;
        logic cf;
    } flags_t;

    typedef enum logic [1:0] {
        RUNNING     = 2'd0,
        HALTED      = 2'd1,
        PROGRAM_END = 2'd2
    } run_status_e;

endpackage

// ==== cpu_control.sv ====
// cpu state sequencer
`timescale 1ns/100ps

module cpu_control #(
    parameter int PC_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  serial_cpu_pkg::dec_t          dec,
    input  serial_cpu_pkg::flags_t        flags,
    input  serial_cpu_pkg::word_t         result,
    output serial_cpu_pkg::step_t         step,
    output logic [PC_WIDTH:0]             i_addr,
    output logic                          busy,
    output serial_cpu_pkg::run_status_e   status
);
    import serial_cpu_pkg::*;

    cpu_state_e          state;
    cpu_state_e          state_nxt;
    logic [PC_WIDTH-1:0] pc;
    logic                pc_end;
    logic                flag_sel;
    logic                branch_taken;

    assign pc_end = &pc;
    assign busy   = (state != IDLE);
    // high byte at the even address, low byte at the odd one
    assign i_addr = {pc, step.load_ir_lo};

    // ------------------------------------------------------------------------
    // branch decision
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (dec.branch_cond[2:1])
            2'b01:   flag_sel = flags.zf;
            2'b10:   flag_sel = flags.nf;
            2'b11:   flag_sel = flags.cf;
            default: flag_sel = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch_uncond ||
                          ((dec.branch_cond[2:1] != 2'b00) && (flag_sel == dec.branch_cond[0]));

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (state)
            IDLE:    state_nxt = start ? IF : IDLE;
            IF:      state_nxt = IF2;
            IF2:     state_nxt = ID;
            ID:      state_nxt = EX;
            EX:      state_nxt = MEM;
            MEM:     state_nxt = MEM2;
            MEM2:    state_nxt = WB;
            WB:      state_nxt = (dec.is_halt || pc_end) ? IDLE : IF;
            default: state_nxt = IDLE;
        endcase
    end

    always_comb
    begin
        step = '0;
        case (state)
            IF:      step.load_ir_hi     = 1'b1;
            IF2:     step.load_ir_lo     = 1'b1;
            ID:      step.latch_operands = 1'b1;
            EX:      step.execute        = 1'b1;
            MEM:     step.mem_lo         = 1'b1;
            MEM2:    step.mem_hi         = 1'b1;
            WB:      step.writeback      = 1'b1;
            default: step = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= IDLE;
            pc     <= '0;
            status <= RUNNING;
        end
        else
        begin
            state <= state_nxt;
            if (state == IDLE && start)
            begin
                pc     <= '0;
                status <= RUNNING;
            end
            else if (state == WB)
            begin
                // last address holds pc unless a branch leaves it
                if (branch_taken)
                    pc <= result[PC_WIDTH-1:0];
                else if (!pc_end)
                    pc <= pc + 1'b1;
                if (dec.is_halt)
                    status <= HALTED;
                else if (pc_end)
                    status <= PROGRAM_END;
            end
        end
    end

    // a finished run never reports RUNNING
    a_end_status: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> status != RUNNING);

    // an unconditional branch carries no flag test
    a_branch_kind: assert property (@(posedge clk) disable iff (!rst_n)
        dec.is_branch_uncond |-> dec.branch_cond == BR_NONE);

endmodule

// ==== instr_decode.sv ====
// instruction register and decoder
`timescale 1ns/100ps

module instr_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  serial_cpu_pkg::step_t      step,
    input  serial_cpu_pkg::byte_t      i_datain,
    input  serial_cpu_pkg::word_t      rd_a,
    input  serial_cpu_pkg::word_t      rd_b,
    output serial_cpu_pkg::reg_idx_t   rs_a,
    output serial_cpu_pkg::reg_idx_t   rs_b,
    output serial_cpu_pkg::dec_t       dec,
    output serial_cpu_pkg::opcode_e    opcode,
    output serial_cpu_pkg::word_t      op_a,
    output serial_cpu_pkg::word_t      op_b,
    output serial_cpu_pkg::word_t      store_data
);
    import serial_cpu_pkg::*;

    typedef enum logic [1:0] {B_VAL3, B_IMM8, B_IMM8_HI, B_REG} b_sel_e;

    instr_t ir;
    logic   a_from_r2;
    b_sel_e b_sel;
    byte_t  imm8;

    assign opcode = ir.opcode;
    assign imm8   = {ir.r2, ir.r3};

    // high byte comes first
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= '0;
        else if (step.load_ir_hi)
            ir[15:8] <= i_datain;
        else if (step.load_ir_lo)
            ir[7:0] <= i_datain;
    end

    // ------------------------------------------------------------------------
    // opcode classification
    // ------------------------------------------------------------------------
    always_comb
    begin
        dec       = '0;
        dec.dst   = ir.r1;
        a_from_r2 = 1'b0;
        b_sel     = B_IMM8;
        case (ir.opcode)
            ADD, SUB, AND, OR, XOR:
            begin
                dec.writes_reg = 1'b1;
                dec.sets_flags = 1'b1;
                a_from_r2      = 1'b1;
                b_sel          = B_REG;
            end
            CMP:
            begin
                dec.sets_flags = 1'b1;
                a_from_r2      = 1'b1;
                b_sel          = B_REG;
            end
            SLL, SRL:
            begin
                dec.writes_reg = 1'b1;
                dec.sets_flags = 1'b1;
                a_from_r2      = 1'b1;
                b_sel          = B_VAL3;
            end
            ADDI, SUBI:
            begin
                dec.writes_reg = 1'b1;
                dec.sets_flags = 1'b1;
            end
            LDIH, SUIH:
            begin
                dec.writes_reg = 1'b1;
                dec.sets_flags = 1'b1;
                b_sel          = B_IMM8_HI;
            end
            SET:   dec.writes_reg = 1'b1;
            LOAD, STORE:
            begin
                dec.is_load  = (ir.opcode == LOAD);
                dec.is_store = (ir.opcode == STORE);
                a_from_r2    = 1'b1;
                b_sel        = B_VAL3;
            end
            JUMP, JMPR: dec.is_branch_uncond = 1'b1;
            BZ:    dec.branch_cond = BR_Z;
            BNZ:   dec.branch_cond = BR_NZ;
            BN:    dec.branch_cond = BR_N;
            BNN:   dec.branch_cond = BR_NN;
            BC:    dec.branch_cond = BR_C;
            BNC:   dec.branch_cond = BR_NC;
            HALT:  dec.is_halt = 1'b1;
            default: dec.branch_cond = BR_NONE;
        endcase
    end

    // port b carries r1 for a store so both registers are read in ID
    assign rs_a = a_from_r2 ? ir.r2[2:0] : ir.r1;
    assign rs_b = dec.is_store ? ir.r1 : ir.r3[2:0];

    always_ff @(posedge clk)
    begin
        if (step.latch_operands)
        begin
            op_a <= (ir.opcode == JUMP) ? '0 : rd_a;
            case (b_sel)
                B_VAL3:    op_b <= {12'h000, ir.r3};
                B_IMM8:    op_b <= {8'h00, imm8};
                B_IMM8_HI: op_b <= {imm8, 8'h00};
                default:   op_b <= rd_b;
            endcase
            store_data <= rd_b;
        end
    end

endmodule

// ==== alu_flags.sv ====
// alu with result and flag registers
`timescale 1ns/100ps

module alu_flags (
    input  logic                      clk,
    input  logic                      rst_n,
    input  serial_cpu_pkg::step_t     step,
    input  serial_cpu_pkg::opcode_e   opcode,
    input  serial_cpu_pkg::dec_t      dec,
    input  serial_cpu_pkg::word_t     op_a,
    input  serial_cpu_pkg::word_t     op_b,
    output serial_cpu_pkg::word_t     result,
    output serial_cpu_pkg::flags_t    flags
);
    import serial_cpu_pkg::*;

    word_t alu_y;
    logic  alu_c;

    // ------------------------------------------------------------------------
    // combinational datapath
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (opcode)
            AND:
                {alu_c, alu_y} = {1'b0, op_a & op_b};
            OR:
                {alu_c, alu_y} = {1'b0, op_a | op_b};
            XOR:
                {alu_c, alu_y} = {1'b0, op_a ^ op_b};
            // shifts keep the old carry
            SLL:
                {alu_c, alu_y} = {flags.cf, op_a << op_b[3:0]};
            SRL:
                {alu_c, alu_y} = {flags.cf, op_a >> op_b[3:0]};
            SET:
                {alu_c, alu_y} = {1'b0, op_b};
            // borrow lands in the carry bit
            SUB, SUBI, SUIH, CMP:
                {alu_c, alu_y} = {1'b0, op_a} - {1'b0, op_b};
            // also address and branch target arithmetic
            default:
                {alu_c, alu_y} = {1'b0, op_a} + {1'b0, op_b};
        endcase
    end

    // ------------------------------------------------------------------------
    // registered result and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result <= '0;
            flags  <= '0;
        end
        else if (step.execute)
        begin
            result <= alu_y;
            if (dec.sets_flags)
            begin
                flags.zf <= (alu_y == '0);
                flags.nf <= alu_y[15];
                flags.cf <= alu_c;
            end
        end
    end

endmodule

// ==== reg_file.sv ====
// general register file
`timescale 1ns/100ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  serial_cpu_pkg::step_t      step,
    input  serial_cpu_pkg::dec_t       dec,
    input  serial_cpu_pkg::reg_idx_t   rs_a,
    input  serial_cpu_pkg::reg_idx_t   rs_b,
    input  serial_cpu_pkg::word_t      result,
    input  serial_cpu_pkg::word_t      ld_word,
    output serial_cpu_pkg::word_t      rd_a,
    output serial_cpu_pkg::word_t      rd_b
);
    import serial_cpu_pkg::*;

    word_t regs [NUM_REGS];

    // two asynchronous read ports
    assign rd_a = regs[rs_a];
    assign rd_b = regs[rs_b];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (step.writeback)
        begin
            // loaded word takes priority over the alu result
            if (dec.is_load)
                regs[dec.dst] <= ld_word;
            else if (dec.writes_reg)
                regs[dec.dst] <= result;
        end
    end

endmodule

// ==== mem_port.sv ====
// byte serial data memory port
`timescale 1ns/100ps

module mem_port #(
    parameter int PC_WIDTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  serial_cpu_pkg::step_t   step,
    input  serial_cpu_pkg::dec_t    dec,
    input  serial_cpu_pkg::word_t   result,
    input  serial_cpu_pkg::word_t   store_data,
    input  serial_cpu_pkg::byte_t   d_datain,
    output logic [PC_WIDTH:0]       d_addr,
    output logic                    d_we,
    output serial_cpu_pkg::byte_t   d_dataout,
    output serial_cpu_pkg::word_t   ld_word
);
    import serial_cpu_pkg::*;

    // low byte at the even address in MEM, high byte at the odd one in MEM2
    assign d_addr    = {result[PC_WIDTH-1:0], step.mem_hi};
    assign d_dataout = step.mem_hi ? store_data[15:8] : store_data[7:0];
    assign d_we      = dec.is_store && (step.mem_lo || step.mem_hi);

    always_ff @(posedge clk)
    begin
        if (dec.is_load && step.mem_lo)
            ld_word[7:0] <= d_datain;
        if (dec.is_load && step.mem_hi)
            ld_word[15:8] <= d_datain;
    end

    // a store always writes both bytes, low first
    a_we_pair: assert property (@(posedge clk) disable iff (!rst_n)
        d_we && !d_addr[0] |=> d_we && d_addr[0]);

endmodule

// ==== serial_cpu.sv ====
// serial cpu top level
`timescale 1ns/100ps

module serial_cpu #(
    parameter int PC_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  serial_cpu_pkg::byte_t         i_datain,
    input  serial_cpu_pkg::byte_t         d_datain,
    output logic [PC_WIDTH:0]             i_addr,
    output logic [PC_WIDTH:0]             d_addr,
    output logic                          d_we,
    output serial_cpu_pkg::byte_t         d_dataout,
    output logic                          busy,
    output serial_cpu_pkg::run_status_e   status
);
    import serial_cpu_pkg::*;

    step_t    step;
    dec_t     dec;
    opcode_e  opcode;
    flags_t   flags;
    word_t    result;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    ld_word;
    word_t    rd_a;
    word_t    rd_b;
    reg_idx_t rs_a;
    reg_idx_t rs_b;

    cpu_control #(.PC_WIDTH(PC_WIDTH)) u_control (
        .clk(clk), .rst_n(rst_n), .start(start),
        .dec(dec), .flags(flags), .result(result),
        .step(step), .i_addr(i_addr), .busy(busy), .status(status)
    );

    instr_decode u_decode (
        .clk(clk), .rst_n(rst_n), .step(step), .i_datain(i_datain),
        .rd_a(rd_a), .rd_b(rd_b), .rs_a(rs_a), .rs_b(rs_b),
        .dec(dec), .opcode(opcode),
        .op_a(op_a), .op_b(op_b), .store_data(store_data)
    );

    alu_flags u_alu (
        .clk(clk), .rst_n(rst_n), .step(step), .opcode(opcode), .dec(dec),
        .op_a(op_a), .op_b(op_b), .result(result), .flags(flags)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .step(step), .dec(dec),
        .rs_a(rs_a), .rs_b(rs_b), .result(result), .ld_word(ld_word),
        .rd_a(rd_a), .rd_b(rd_b)
    );

    mem_port #(.PC_WIDTH(PC_WIDTH)) u_mem (
        .clk(clk), .rst_n(rst_n), .step(step), .dec(dec),
        .result(result), .store_data(store_data), .d_datain(d_datain),
        .d_addr(d_addr), .d_we(d_we), .d_dataout(d_dataout), .ld_word(ld_word)
    );

endmodule

// ==== cpu_ref_model.svh ====
// instruction level cpu model
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

    // architectural state kept across programs like the DUT's
    word_t             m_regs [NUM_REGS] = '{default: '0};
    flags_t            m_flags = '0;
    byte_t             m_dmem [MEM_BYTES];
    logic [PC_WIDTH:0] exp_addr [$];
    byte_t             exp_data [$];

    // y carries the carry or borrow in bit 16
    task automatic model_alu(input reg_idx_t dst, input logic [16:0] y, input bit wr);
        m_flags.zf = (y[15:0] == 16'h0000);
        m_flags.nf = y[15];
        m_flags.cf = y[16];
        if (wr)
            m_regs[dst] = y[15:0];
    endtask

    // low byte at the even address
    task automatic model_store(input logic [PC_WIDTH-1:0] ea, input word_t d);
        m_dmem[{ea, 1'b0}] = d[7:0];
        m_dmem[{ea, 1'b1}] = d[15:8];
        exp_addr.push_back({ea, 1'b0});
        exp_data.push_back(d[7:0]);
        exp_addr.push_back({ea, 1'b1});
        exp_data.push_back(d[15:8]);
    endtask

    task automatic run_model(output int n_exec, output run_status_e fin);
        instr_t              ins;
        int                  pc;
        word_t               a;
        word_t               b;
        word_t               d;
        word_t               sum;
        word_t               tgt;
        logic [16:0]         imm17;
        logic [PC_WIDTH-1:0] ea;
        logic                taken;
        bit                  done;
        pc     = 0;
        n_exec = 0;
        done   = 1'b0;
        fin    = RUNNING;
        exp_addr.delete();
        exp_data.delete();
        while (!done && n_exec < MAX_STEPS)
        begin
            ins   = {imem[2 * pc], imem[2 * pc + 1]};
            a     = m_regs[ins.r2[2:0]];
            b     = m_regs[ins.r3[2:0]];
            d     = m_regs[ins.r1];
            imm17 = {9'h000, ins.r2, ins.r3};
            sum   = a + {12'h000, ins.r3};
            ea    = sum[PC_WIDTH-1:0];
            tgt   = d + {8'h00, ins.r2, ins.r3};
            taken = 1'b0;
            n_exec++;
            case (ins.opcode)
                ADD:   model_alu(ins.r1, {1'b0, a} + {1'b0, b}, 1'b1);
                SUB:   model_alu(ins.r1, {1'b0, a} - {1'b0, b}, 1'b1);
                CMP:   model_alu(ins.r1, {1'b0, a} - {1'b0, b}, 1'b0);
                AND:   model_alu(ins.r1, {1'b0, a & b}, 1'b1);
                OR:    model_alu(ins.r1, {1'b0, a | b}, 1'b1);
                XOR:   model_alu(ins.r1, {1'b0, a ^ b}, 1'b1);
                SLL:   model_alu(ins.r1, {m_flags.cf, a << ins.r3}, 1'b1);
                SRL:   model_alu(ins.r1, {m_flags.cf, a >> ins.r3}, 1'b1);
                ADDI:  model_alu(ins.r1, {1'b0, d} + imm17, 1'b1);
                SUBI:  model_alu(ins.r1, {1'b0, d} - imm17, 1'b1);
                LDIH:  model_alu(ins.r1, {1'b0, d} + {1'b0, ins.r2, ins.r3, 8'h00}, 1'b1);
                SUIH:  model_alu(ins.r1, {1'b0, d} - {1'b0, ins.r2, ins.r3, 8'h00}, 1'b1);
                SET:   m_regs[ins.r1] = {8'h00, ins.r2, ins.r3};
                LOAD:  m_regs[ins.r1] = {m_dmem[{ea, 1'b1}], m_dmem[{ea, 1'b0}]};
                STORE: model_store(ea, d);
                JUMP:
                begin
                    taken = 1'b1;
                    tgt   = {8'h00, ins.r2, ins.r3};
                end
                JMPR:  taken = 1'b1;
                BZ:    taken = m_flags.zf;
                BNZ:   taken = !m_flags.zf;
                BN:    taken = m_flags.nf;
                BNN:   taken = !m_flags.nf;
                BC:    taken = m_flags.cf;
                BNC:   taken = !m_flags.cf;
                HALT:
                begin
                    fin  = HALTED;
                    done = 1'b1;
                end
                default: ;
            endcase
            if (!done)
            begin
                // the last address ends the program even on a taken branch
                if (pc == PC_LAST)
                begin
                    fin  = PROGRAM_END;
                    done = 1'b1;
                end
                else if (taken)
                    pc = int'(tgt[PC_WIDTH-1:0]);
                else
                    pc++;
            end
        end
    endtask

`endif

// ==== tb_serial_cpu.sv ====
// serial cpu testbench
`timescale 1ns/100ps

module tb_serial_cpu;
    import serial_cpu_pkg::*;

    localparam int PC_WIDTH   = 8;
    localparam int MEM_BYTES  = 2 ** (PC_WIDTH + 1);
    localparam int PC_LAST    = 2 ** PC_WIDTH - 1;
    localparam int MAX_STEPS  = 4 * PC_LAST;
    localparam int MAX_CYCLES = 7 * MAX_STEPS + 16;

    logic              clk;
    logic              rst_n;
    logic              start;
    byte_t             i_datain;
    byte_t             d_datain;
    logic [PC_WIDTH:0] i_addr;
    logic [PC_WIDTH:0] d_addr;
    logic              d_we;
    byte_t             d_dataout;
    logic              busy;
    run_status_e       status;

    byte_t             imem [MEM_BYTES];
    byte_t             dmem [MEM_BYTES];
    logic [PC_WIDTH:0] obs_addr [$];
    byte_t             obs_data [$];
    int                checks = 0;
    int                errors = 0;
    bit                timed_out = 1'b0;

    opcode_e alu_ops [13] = '{ADD, SUB, CMP, AND, OR, XOR, SLL, SRL,
                              ADDI, SUBI, LDIH, SUIH, SET};
    opcode_e br_ops [8]   = '{JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC};

    `include "cpu_ref_model.svh"

    serial_cpu #(.PC_WIDTH(PC_WIDTH)) DUT (
        .clk(clk), .rst_n(rst_n), .start(start),
        .i_datain(i_datain), .d_datain(d_datain),
        .i_addr(i_addr), .d_addr(d_addr), .d_we(d_we), .d_dataout(d_dataout),
        .busy(busy), .status(status)
    );

    // both memories answer combinationally
    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // store bytes are stable mid cycle
    always @(negedge clk)
    begin
        if (d_we)
        begin
            dmem[d_addr] = d_dataout;
            obs_addr.push_back(d_addr);
            obs_data.push_back(d_dataout);
        end
    end

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic put_instr(input int pc, input opcode_e op, input int r1,
                             input int r2, input int r3);
        instr_t ins;
        ins.opcode       = op;
        ins.r1           = reg_idx_t'(r1);
        ins.r2           = 4'(r2);
        ins.r3           = 4'(r3);
        imem[2 * pc]     = ins[15:8];
        imem[2 * pc + 1] = ins[7:0];
    endtask

    // ------------------------------------------------------------------------
    // program generator
    // ------------------------------------------------------------------------
    task automatic gen_program(input int n_body, input bit use_br, input bit use_mem,
                               input bit with_halt);
        int kind;
        int tgt;
        for (int a = 0; a < MEM_BYTES; a++)
        begin
            // NOP words whose unused fields follow the address
            imem[a] = a[0] ? byte_t'(a >> 1) : {5'b00000, a[8:6]};
            dmem[a] = byte_t'($urandom);
        end
        for (int pc = 0; pc < n_body; pc++)
        begin
            kind = $urandom_range(9, 0);
            if (use_br && kind < 2)
            begin
                // r7 is never written, so the target is imm8 and lies ahead
                tgt = $urandom_range(n_body, pc + 1);
                put_instr(pc, br_ops[$urandom_range(7, 0)], 7, tgt >> 4, tgt & 15);
            end
            else if (use_mem && kind < 3)
                put_instr(pc, LOAD, $urandom_range(6, 0), $urandom_range(15, 0),
                          $urandom_range(15, 0));
            else if (use_mem && kind < 4)
                put_instr(pc, STORE, $urandom_range(7, 0), $urandom_range(15, 0),
                          $urandom_range(15, 0));
            else
                put_instr(pc, alu_ops[$urandom_range(12, 0)], $urandom_range(6, 0),
                          $urandom_range(15, 0), $urandom_range(15, 0));
        end
        // dump all registers to words 0 to 7
        for (int r = 0; r < NUM_REGS; r++)
            put_instr(n_body + r, STORE, r, 7, r);
        if (with_halt)
            put_instr(n_body + NUM_REGS, HALT, 0, 0, 0);
    endtask

    // ------------------------------------------------------------------------
    // one program run against the model
    // ------------------------------------------------------------------------
    task automatic run_program(input string name);
        int          n_exec;
        int          cycles;
        run_status_e fin;
        m_dmem = dmem;
        run_model(n_exec, fin);
        obs_addr.delete();
        obs_data.delete();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        checks++;
        assert (busy)
        else
        begin
            errors++;
            $display("%s: busy did not rise the cycle after start", name);
        end
        check_value({name, " status while running"}, status, RUNNING);
        check_value({name, " first fetch address"}, i_addr, 0);
        cycles = 1;
        while (busy && cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            #1 cycles++;
        end
        checks++;
        assert (!busy)
        else
        begin
            errors++;
            timed_out = 1'b1;
            $display("%s: busy still high after %0d cycles, run abandoned", name, cycles);
        end
        if (!timed_out)
        begin
            check_value({name, " cycles"}, cycles, 7 * n_exec + 1);
            check_value({name, " final status"}, status, fin);
            check_value({name, " d_we when idle"}, d_we, 0);
            check_value({name, " write count"}, obs_addr.size(), exp_addr.size());
            for (int i = 0; i < obs_addr.size() && i < exp_addr.size(); i++)
            begin
                check_value($sformatf("%s write %0d address", name, i), obs_addr[i],
                            exp_addr[i]);
                check_value($sformatf("%s write %0d data", name, i), obs_data[i],
                            exp_data[i]);
            end
        end
    endtask

    task automatic run_batch(input string name, input int count, input int n_body,
                             input bit use_br, input bit use_mem, input bit with_halt);
        for (int p = 0; p < count && !timed_out; p++)
        begin
            gen_program(n_body, use_br, use_mem, with_halt);
            run_program($sformatf("%s %0d", name, p));
        end
    endtask

    initial
    begin
        void'($urandom(83));
        start = 1'b0;
        rst_n = 1'b0;
        gen_program(0, 1'b0, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("busy after reset", busy, 0);
        check_value("d_we after reset", d_we, 0);
        check_value("status after reset", status, RUNNING);

        run_batch("alu", 6, 40, 1'b0, 1'b0, 1'b1);
        run_batch("branch", 6, 60, 1'b1, 1'b0, 1'b1);
        run_batch("memory", 6, 50, 1'b0, 1'b1, 1'b1);
        run_batch("mixed", 6, 120, 1'b1, 1'b1, 1'b1);
        // no HALT, so the run ends at the last address
        run_batch("no halt", 2, 80, 1'b1, 1'b1, 1'b0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== serial_cpu.f ====
+incdir+.
serial_cpu_pkg.sv
cpu_control.sv
instr_decode.sv
alu_flags.sv
reg_file.sv
mem_port.sv
serial_cpu.sv
tb_serial_cpu.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_serial_cpu
SRCS := serial_cpu_pkg.sv cpu_control.sv instr_decode.sv alu_flags.sv reg_file.sv \
        mem_port.sv serial_cpu.sv tb_serial_cpu.sv cpu_ref_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) serial_cpu.f
	verilator --binary --assert -Wno-fatal --top-module tb_serial_cpu -f serial_cpu.f -o Vtb_serial_cpu

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x 'NO ERRORS' > /dev/null

clean:
	rm -rf obj_dir
